// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_pipeline_cpu \
    -f src.f -o tb_pipeline_cpu_sim \
    && ./obj_dir/tb_pipeline_cpu_sim \
    || exit 1

// File: source/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [63:0] line_t;    // one main-memory word
    typedef logic [4:0]  reg_idx_t;
    typedef logic [63:0] order_t;

    typedef enum logic [1:0] {alu_add, alu_sub, alu_pass_b} alu_op_t;

    typedef enum logic [2:0] {idle, ifetch, dread, rmw_read, rmw_write} bridge_state_t;

    // opcode field, inst[6:0]
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_zero = 3'b000;   // addi, add/sub, beq
    localparam logic [2:0] f3_word = 3'b010;   // lw, sw
    localparam logic [6:0] funct7_sub = 7'b0100000;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_v;
        word_t    rs2_v;
        word_t    imm;
        reg_idx_t rd;
        alu_op_t  alu_op;
        logic     use_imm;
        logic     mem_read;
        logic     mem_write;
        logic     is_branch;
        logic     regf_we;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_v;
        logic     mem_read;
        logic     mem_write;
        logic     regf_we;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        word_t    rd_v;
        logic     regf_we;
    } mem_wb_t;

endpackage

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::if_id_t   if_id,
    input  logic               wb_we,
    input  core_pkg::reg_idx_t wb_rd,
    input  core_pkg::word_t    wb_v,
    output core_pkg::id_ex_t   id_ex_next
);
    import core_pkg::*;

    word_t    regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     legal;
    logic     writes_rd;

    assign opcode = if_id.inst[6:0];
    assign funct3 = if_id.inst[14:12];
    assign funct7 = if_id.inst[31:25];
    assign rs1    = if_id.inst[19:15];
    assign rs2    = if_id.inst[24:20];
    assign rd     = if_id.inst[11:7];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_we && wb_rd != '0)
            regs[wb_rd] <= wb_v;   // x0 stays zero
    end

    always_comb
    begin
        legal     = 1'b0;
        writes_rd = 1'b0;
        id_ex_next.imm       = '0;
        id_ex_next.alu_op    = alu_pass_b;
        id_ex_next.use_imm   = 1'b0;
        id_ex_next.mem_read  = 1'b0;
        id_ex_next.mem_write = 1'b0;
        id_ex_next.is_branch = 1'b0;

        case (opcode)
            op_imm:
            begin
                legal     = (funct3 == f3_zero);
                writes_rd = 1'b1;
                id_ex_next.imm     = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
                id_ex_next.alu_op  = alu_add;
                id_ex_next.use_imm = 1'b1;
            end
            op_reg:
            begin
                legal     = (funct3 == f3_zero) && ((funct7 & ~funct7_sub) == '0);
                writes_rd = 1'b1;
                id_ex_next.alu_op = (funct7 == funct7_sub) ? alu_sub : alu_add;
            end
            op_load:
            begin
                legal     = (funct3 == f3_word);
                writes_rd = 1'b1;
                id_ex_next.imm      = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
                id_ex_next.alu_op   = alu_add;
                id_ex_next.use_imm  = 1'b1;
                id_ex_next.mem_read = 1'b1;
            end
            op_store:
            begin
                legal = (funct3 == f3_word);
                id_ex_next.imm       = {{20{if_id.inst[31]}}, if_id.inst[31:25], rd};
                id_ex_next.alu_op    = alu_add;
                id_ex_next.use_imm   = 1'b1;
                id_ex_next.mem_write = 1'b1;
            end
            op_branch:
            begin
                legal = (funct3 == f3_zero);   // beq only
                id_ex_next.imm = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
                                  if_id.inst[30:25], if_id.inst[11:8], 1'b0};
                id_ex_next.is_branch = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        id_ex_next.valid   = if_id.valid & legal;   // unknown encodings become bubbles
        id_ex_next.pc      = if_id.pc;
        id_ex_next.rs1     = rs1;
        id_ex_next.rs2     = rs2;
        id_ex_next.rd      = rd;
        id_ex_next.regf_we = writes_rd && (rd != '0);
        // read-during-write returns the new value
        id_ex_next.rs1_v   = (wb_we && wb_rd == rs1 && rs1 != '0) ? wb_v : regs[rs1];
        id_ex_next.rs2_v   = (wb_we && wb_rd == rs2 && rs2 != '0) ? wb_v : regs[rs2];
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  core_pkg::id_ex_t   id_ex,
    input  core_pkg::reg_idx_t mem_rd,
    input  core_pkg::word_t    mem_v,
    input  logic               mem_we,
    input  core_pkg::reg_idx_t wb_rd,
    input  core_pkg::word_t    wb_v,
    input  logic               wb_we,
    output core_pkg::ex_mem_t  ex_mem_next,
    output logic               br_taken,
    output core_pkg::addr_t    br_target
);
    import core_pkg::*;

    word_t op_a;
    word_t rs2_f;   // forwarded rs2, also the store data
    word_t op_b;
    word_t result;

    // newest producer wins
    always_comb
    begin
        if (mem_we && mem_rd != '0 && mem_rd == id_ex.rs1)
            op_a = mem_v;
        else if (wb_we && wb_rd != '0 && wb_rd == id_ex.rs1)
            op_a = wb_v;
        else
            op_a = id_ex.rs1_v;

        if (mem_we && mem_rd != '0 && mem_rd == id_ex.rs2)
            rs2_f = mem_v;
        else if (wb_we && wb_rd != '0 && wb_rd == id_ex.rs2)
            rs2_f = wb_v;
        else
            rs2_f = id_ex.rs2_v;
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_f;

    always_comb
    begin
        case (id_ex.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            default: result = op_b;
        endcase
    end

    assign br_taken  = id_ex.valid & id_ex.is_branch & (op_a == rs2_f);
    assign br_target = id_ex.pc + id_ex.imm;

    assign ex_mem_next.valid      = id_ex.valid;
    assign ex_mem_next.pc         = id_ex.pc;
    assign ex_mem_next.rd         = id_ex.rd;
    assign ex_mem_next.alu_result = result;
    assign ex_mem_next.store_v    = rs2_f;
    assign ex_mem_next.mem_read   = id_ex.mem_read;
    assign ex_mem_next.mem_write  = id_ex.mem_write;
    assign ex_mem_next.regf_we    = id_ex.regf_we;

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter core_pkg::addr_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               br_taken,
    input  core_pkg::addr_t    br_target,
    mem_req_if.client          imem,
    output logic               istall,
    output core_pkg::if_id_t   if_id_next
);
    import core_pkg::*;

    addr_t pc;
    word_t inst_q;     // instruction held while the pipeline is stalled
    logic  have_q;
    logic  inst_ok;

    // request stays open until the bridge answers
    assign imem.addr  = pc;
    assign imem.read  = ~have_q;
    assign imem.write = 1'b0;
    assign imem.wdata = '0;

    assign inst_ok = have_q | imem.resp;
    assign istall  = ~inst_ok;

    assign if_id_next.valid = inst_ok & ~br_taken;   // squashed path is dropped
    assign if_id_next.pc    = pc;
    assign if_id_next.inst  = have_q ? inst_q : imem.rdata;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc     <= reset_pc;
            have_q <= 1'b0;
        end
        else if (!stall && inst_ok)
        begin
            pc     <= br_taken ? br_target : pc + 32'd4;
            have_q <= 1'b0;
        end
        else if (imem.resp)
            have_q <= 1'b1;   // park it until dstall clears
    end

    always_ff @(posedge clk)
    begin
        if (imem.resp)
            inst_q <= imem.rdata;
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("fetch pc %h is not word aligned", pc);

endmodule

// File: source/mem_bridge.sv
`timescale 1ns/1ps

module mem_bridge (
    input  logic             clk,
    input  logic             rst,
    mem_req_if.server        imem,
    mem_req_if.server        dmem,
    output core_pkg::addr_t  bmem_addr,
    output logic             bmem_read,
    output logic             bmem_write,
    output core_pkg::line_t  bmem_wdata,
    input  logic             bmem_ready,
    input  core_pkg::addr_t  bmem_raddr,
    input  core_pkg::line_t  bmem_rdata,
    input  logic             bmem_rvalid
);
    import core_pkg::*;

    bridge_state_t state;
    addr_t sel_addr;
    line_t line_q;       // returned line, or the merged line for a store
    line_t merged;
    word_t half_v;
    logic  issued_q;     // read accepted by main memory
    logic  got_q;        // read data is in line_q
    logic  read_state;
    logic  rvalid_hit;

    assign sel_addr   = (state == ifetch) ? imem.addr : dmem.addr;
    assign bmem_addr  = {sel_addr[31:3], 3'b000};   // 8-byte aligned
    assign read_state = (state == ifetch) || (state == dread) || (state == rmw_read);
    assign bmem_read  = read_state && !issued_q;
    assign bmem_write = (state == rmw_write);
    assign bmem_wdata = line_q;
    assign rvalid_hit = bmem_rvalid && issued_q && (bmem_raddr == bmem_addr);

    // store word replaces one half, the other half comes from memory
    assign merged = dmem.addr[2] ? {dmem.wdata, bmem_rdata[31:0]}
                                 : {bmem_rdata[63:32], dmem.wdata};

    assign half_v     = sel_addr[2] ? line_q[63:32] : line_q[31:0];
    assign imem.rdata = half_v;
    assign dmem.rdata = half_v;
    assign imem.resp  = (state == ifetch) && got_q;
    assign dmem.resp  = ((state == dread) && got_q) || ((state == rmw_write) && bmem_ready);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= idle;
            issued_q <= 1'b0;
            got_q    <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    issued_q <= 1'b0;
                    got_q    <= 1'b0;
                    if (dmem.read)
                        state <= dread;      // data side first
                    else if (dmem.write)
                        state <= rmw_read;
                    else if (imem.read)
                        state <= ifetch;
                end
                ifetch, dread:
                begin
                    if (bmem_read && bmem_ready)
                        issued_q <= 1'b1;
                    if (rvalid_hit)
                        got_q <= 1'b1;
                    if (got_q)
                        state <= idle;   // resp goes out this cycle
                end
                rmw_read:
                begin
                    if (bmem_read && bmem_ready)
                        issued_q <= 1'b1;
                    if (rvalid_hit)
                        state <= rmw_write;
                end
                rmw_write:
                    if (bmem_ready)
                        state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rvalid_hit)
            line_q <= (state == rmw_read) ? merged : bmem_rdata;
    end

    // a request that waits for bmem_ready stays as it is
    req_held: assert property (@(posedge clk) disable iff (rst)
        (bmem_read || bmem_write) && !bmem_ready |=> bmem_read == $past(bmem_read)
            && bmem_write == $past(bmem_write) && $stable(bmem_addr) && $stable(bmem_wdata))
        else $error("bmem request changed while bmem_ready was low");

    imem_resp_requested: assert property (@(posedge clk) disable iff (rst)
        imem.resp |-> imem.read)
        else $error("fetch response without a fetch request");

    dmem_resp_requested: assert property (@(posedge clk) disable iff (rst)
        dmem.resp |-> (dmem.read || dmem.write))
        else $error("data response without a data request");

endmodule

// File: source/mem_req_if.sv
`timescale 1ns/1ps

// 32-bit request channel between a pipeline client and the memory bridge
interface mem_req_if;
    import core_pkg::*;

    addr_t addr;
    logic  read;
    logic  write;
    word_t wdata;
    word_t rdata;   // valid with resp on a read
    logic  resp;    // one-cycle pulse

    modport client (
        output addr, read, write, wdata,
        input  rdata, resp
    );

    modport server (
        input  addr, read, write, wdata,
        output rdata, resp
    );

endinterface

// File: source/pipeline_cpu.sv
`timescale 1ns/1ps

module pipeline_cpu #(
    parameter core_pkg::addr_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst,

    output core_pkg::addr_t    bmem_addr,
    output logic               bmem_read,
    output logic               bmem_write,
    output core_pkg::line_t    bmem_wdata,
    input  logic               bmem_ready,
    input  core_pkg::addr_t    bmem_raddr,
    input  core_pkg::line_t    bmem_rdata,
    input  logic               bmem_rvalid,

    output logic               commit_valid,
    output core_pkg::order_t   commit_order,
    output core_pkg::addr_t    commit_pc,
    output core_pkg::reg_idx_t commit_rd,
    output core_pkg::word_t    commit_rd_v
);
    import core_pkg::*;

    if_id_t  if_id_next, if_id;
    id_ex_t  id_ex_next, id_ex;
    ex_mem_t ex_mem_next, ex_mem;
    mem_wb_t mem_wb_next, mem_wb;

    logic   istall;
    logic   dstall;
    logic   stall;
    logic   br_taken;
    addr_t  br_target;
    logic   got_resp;    // dmem answered, waiting for fetch to catch up
    word_t  load_q;
    word_t  load_v;
    logic   mem_access;
    order_t order_q;

    mem_req_if imem ();
    mem_req_if dmem ();

    assign stall = istall | dstall;

    assign mem_access = ex_mem.valid & (ex_mem.mem_read | ex_mem.mem_write);
    assign dstall     = mem_access & ~(dmem.resp | got_resp);

    // strobes drop once answered, even if fetch still stalls
    assign dmem.addr  = ex_mem.alu_result;
    assign dmem.wdata = ex_mem.store_v;
    assign dmem.read  = ex_mem.valid & ex_mem.mem_read & ~got_resp;
    assign dmem.write = ex_mem.valid & ex_mem.mem_write & ~got_resp;

    assign load_v = got_resp ? load_q : dmem.rdata;

    assign mem_wb_next.valid   = ex_mem.valid;
    assign mem_wb_next.pc      = ex_mem.pc;
    assign mem_wb_next.rd      = ex_mem.rd;
    assign mem_wb_next.rd_v    = ex_mem.mem_read ? load_v : ex_mem.alu_result;
    assign mem_wb_next.regf_we = ex_mem.regf_we;

    always_ff @(posedge clk)
    begin
        if (rst)
            got_resp <= 1'b0;
        else if (!stall)
            got_resp <= 1'b0;
        else if (dmem.resp)
            got_resp <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (dmem.resp)
            load_q <= dmem.rdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end
        else if (stall)
        begin
            if (br_taken)
                if_id <= '0;   // everything else holds
        end
        else
        begin
            if_id  <= br_taken ? '0 : if_id_next;
            id_ex  <= br_taken ? '0 : id_ex_next;
            ex_mem <= ex_mem_next;
            mem_wb <= mem_wb_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            order_q <= '0;
        else if (commit_valid)
            order_q <= order_q + 64'd1;
    end

    assign commit_valid = mem_wb.valid & ~stall;
    assign commit_order = order_q;
    assign commit_pc    = mem_wb.pc;
    assign commit_rd    = mem_wb.regf_we ? mem_wb.rd : '0;
    assign commit_rd_v  = mem_wb.regf_we ? mem_wb.rd_v : '0;

    fetch_stage #(.reset_pc(reset_pc)) fetch_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .imem       (imem),
        .istall     (istall),
        .if_id_next (if_id_next)
    );

    decode_stage decode_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .if_id      (if_id),
        .wb_we      (mem_wb.valid & mem_wb.regf_we),
        .wb_rd      (mem_wb.rd),
        .wb_v       (mem_wb.rd_v),
        .id_ex_next (id_ex_next)
    );

    execute_stage execute_stage_inst (
        .id_ex       (id_ex),
        .mem_rd      (ex_mem.rd),
        .mem_v       (mem_wb_next.rd_v),   // load value once returned
        .mem_we      (ex_mem.valid & ex_mem.regf_we),
        .wb_rd       (mem_wb.rd),
        .wb_v        (mem_wb.rd_v),
        .wb_we       (mem_wb.valid & mem_wb.regf_we),
        .ex_mem_next (ex_mem_next),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    mem_bridge mem_bridge_inst (
        .clk         (clk),
        .rst         (rst),
        .imem        (imem),
        .dmem        (dmem),
        .bmem_addr   (bmem_addr),
        .bmem_read   (bmem_read),
        .bmem_write  (bmem_write),
        .bmem_wdata  (bmem_wdata),
        .bmem_ready  (bmem_ready),
        .bmem_raddr  (bmem_raddr),
        .bmem_rdata  (bmem_rdata),
        .bmem_rvalid (bmem_rvalid)
    );

endmodule

// File: src.f
source/core_pkg.sv
source/mem_req_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_bridge.sv
source/pipeline_cpu.sv
test/tb_pipeline_cpu.sv

// File: test/tb_pipeline_cpu.sv
`timescale 1ns/1ps

module tb_pipeline_cpu;
    import core_pkg::*;

    localparam addr_t reset_pc  = 32'h0000_0104;   // not 8-byte aligned on purpose
    localparam int    mem_lines = 256;

    logic     clk;
    logic     rst;
    addr_t    bmem_addr;
    logic     bmem_read;
    logic     bmem_write;
    line_t    bmem_wdata;
    logic     bmem_ready;
    addr_t    bmem_raddr;
    line_t    bmem_rdata;
    logic     bmem_rvalid;
    logic     commit_valid;
    order_t   commit_order;
    addr_t    commit_pc;
    reg_idx_t commit_rd;
    word_t    commit_rd_v;

    line_t    mem [mem_lines];
    line_t    saved_mem [mem_lines];
    word_t    prog [$];
    order_t   c_order [$];
    addr_t    c_pc [$];
    reg_idx_t c_rd [$];
    word_t    c_rdv [$];
    order_t   s_order [$];
    addr_t    s_pc [$];
    reg_idx_t s_rd [$];
    word_t    s_rdv [$];
    addr_t    wr_addr [$];
    line_t    wr_line [$];
    line_t    wr_prior [$];   // line contents before each write

    logic        samp_rst;
    logic        samp_rand;
    logic        rd_acc;
    logic        wr_acc;
    addr_t       acc_addr;
    line_t       acc_line;
    logic        ready_random;
    logic [15:0] lfsr;
    logic [1:0]  pend_v;      // read return pipe, two cycles deep
    addr_t       pend_a [2];

    pipeline_cpu #(.reset_pc(reset_pc)) pipeline_cpu_inst (
        .clk          (clk),
        .rst          (rst),
        .bmem_addr    (bmem_addr),
        .bmem_read    (bmem_read),
        .bmem_write   (bmem_write),
        .bmem_wdata   (bmem_wdata),
        .bmem_ready   (bmem_ready),
        .bmem_raddr   (bmem_raddr),
        .bmem_rdata   (bmem_rdata),
        .bmem_rvalid  (bmem_rvalid),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_rd_v  (commit_rd_v)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // rv32i encodings
    function automatic word_t enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t enc_add(input int rd, input int rs1, input int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t enc_sub(input int rd, input int rs1, input int rs2);
        return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t enc_lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // low three opcode bits are 000 or 111, never 011, so fetched filler is always illegal
    function automatic line_t line_fill(input int i);
        addr_t a;
        a = addr_t'(i * 8);
        return {~a, a ^ 32'h5a5a_0000};
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // sample where everything is stable, mid cycle
    always @(negedge clk)
    begin
        samp_rst  = rst;
        samp_rand = ready_random;
        rd_acc    = bmem_read && bmem_ready;
        wr_acc    = bmem_write && bmem_ready;
        acc_addr  = bmem_addr;
        acc_line  = bmem_wdata;
        if (!rst && commit_valid)
        begin
            c_order.push_back(commit_order);
            c_pc.push_back(commit_pc);
            c_rd.push_back(commit_rd);
            c_rdv.push_back(commit_rd_v);
        end
    end

    // main memory model
    always @(posedge clk)
    begin
        #1;
        if (samp_rst)
        begin
            pend_v      = 2'b00;
            bmem_rvalid = 1'b0;
        end
        else
        begin
            if (wr_acc)
            begin
                wr_addr.push_back(acc_addr);
                wr_line.push_back(acc_line);
                wr_prior.push_back(mem[acc_addr[10:3]]);
                mem[acc_addr[10:3]] = acc_line;
            end
            bmem_rvalid = pend_v[1];
            bmem_raddr  = pend_a[1];
            bmem_rdata  = pend_v[1] ? mem[pend_a[1][10:3]] : '0;
            pend_v      = {pend_v[0], rd_acc};
            pend_a[1]   = pend_a[0];
            pend_a[0]   = acc_addr;
        end
        if (samp_rand)
        begin
            bmem_ready = lfsr[0];   // one lfsr step per bit
            lfsr       = lfsr_next(lfsr);
        end
        else
            bmem_ready = 1'b1;
    end

    task automatic write_word(input addr_t a, input word_t w);
        if (a[2])
            mem[a[10:3]][63:32] = w;
        else
            mem[a[10:3]][31:0] = w;
    endtask

    // program goes in while the core is held in reset, a self loop ends it
    task automatic reset_and_load();
        @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);
        for (int i = 0; i < mem_lines; i++)
            mem[i] = line_fill(i);
        foreach (prog[k])
            write_word(reset_pc + addr_t'(4 * k), prog[k]);
        write_word(reset_pc + addr_t'(4 * prog.size()), enc_beq(0, 0, 0));
        c_order.delete();
        c_pc.delete();
        c_rd.delete();
        c_rdv.delete();
        wr_addr.delete();
        wr_line.delete();
        wr_prior.delete();
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            compare_values("bmem_read in reset", bmem_read, 0);
            compare_values("bmem_write in reset", bmem_write, 0);
            compare_values("commit_valid in reset", commit_valid, 0);
        end
        @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic wait_for_commits(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (c_pc.size() < n)
        begin
            if (cycles >= limit)
            begin
                $display("timeout: only %0d of %0d instructions committed", c_pc.size(), n);
                stop_run();
            end
            else
            begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_commit(input int k, input int slot, input int rd, input word_t v);
        compare_values($sformatf("commit_order[%0d]", k), c_order[k], 64'(k));
        compare_values($sformatf("commit_pc[%0d]", k), c_pc[k], reset_pc + addr_t'(4 * slot));
        compare_values($sformatf("commit_rd[%0d]", k), c_rd[k], 64'(rd));
        compare_values($sformatf("commit_rd_v[%0d]", k), c_rdv[k], v);
    endtask

    task automatic check_store(input int k, input addr_t a, input word_t d);
        compare_values($sformatf("write %0d bmem_addr", k), wr_addr[k], {a[31:3], 3'b000});
        if (a[2])
        begin
            compare_values($sformatf("write %0d upper half", k), wr_line[k][63:32], d);
            compare_values($sformatf("write %0d lower half", k), wr_line[k][31:0],
                           wr_prior[k][31:0]);
        end
        else
        begin
            compare_values($sformatf("write %0d lower half", k), wr_line[k][31:0], d);
            compare_values($sformatf("write %0d upper half", k), wr_line[k][63:32],
                           wr_prior[k][63:32]);
        end
    endtask

    task automatic test_reset_fetch();
        int cycles;
        prog.delete();
        prog.push_back(enc_addi(1, 0, 1));
        reset_and_load();
        @(negedge clk);
        compare_values("bmem_read after reset", bmem_read, 0);
        compare_values("commit_valid after reset", commit_valid, 0);
        cycles = 0;
        while (!bmem_read)
        begin
            if (cycles >= 20)
            begin
                $display("timeout: no instruction fetch after reset");
                stop_run();
            end
            else
            begin
                @(negedge clk);
                cycles++;
            end
        end
        compare_values("first bmem_addr", bmem_addr, {reset_pc[31:3], 3'b000});
        compare_values("bmem_write at first fetch", bmem_write, 0);
        compare_values("commit_valid at first fetch", commit_valid, 0);
        @(posedge clk);
        wait_for_commits(1, 100);
        check_commit(0, 0, 1, 32'd1);
    endtask

    task automatic test_alu_sequence();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 5));
        prog.push_back(enc_addi(2, 0, 12));
        prog.push_back(enc_addi(3, 0, -3));
        prog.push_back(enc_add(4, 1, 2));
        prog.push_back(enc_sub(5, 2, 1));
        prog.push_back(enc_add(6, 3, 1));
        prog.push_back(enc_sub(7, 3, 2));
        reset_and_load();
        wait_for_commits(7, 400);
        check_commit(0, 0, 1, 32'd5);
        check_commit(1, 1, 2, 32'd12);
        check_commit(2, 2, 3, 32'hffff_fffd);
        check_commit(3, 3, 4, 32'd17);
        check_commit(4, 4, 5, 32'd7);
        check_commit(5, 5, 6, 32'd2);
        check_commit(6, 6, 7, 32'hffff_fff1);
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 10));
        prog.push_back(enc_addi(2, 1, 3));     // distance 1
        prog.push_back(enc_add(3, 1, 2));      // distances 2 and 1
        prog.push_back(enc_sub(4, 3, 2));
        prog.push_back(enc_add(5, 4, 4));
        prog.push_back(enc_addi(5, 5, -1));
        prog.push_back(enc_sub(6, 5, 3));
        prog.push_back(enc_addi(0, 1, 7));     // x0 must stay zero
        prog.push_back(enc_add(7, 0, 6));
        reset_and_load();
        wait_for_commits(9, 400);
        check_commit(0, 0, 1, 32'd10);
        check_commit(1, 1, 2, 32'd13);
        check_commit(2, 2, 3, 32'd23);
        check_commit(3, 3, 4, 32'd10);
        check_commit(4, 4, 5, 32'd20);
        check_commit(5, 5, 5, 32'd19);
        check_commit(6, 6, 6, 32'hffff_fffc);
        check_commit(7, 7, 0, 32'd0);
        check_commit(8, 8, 7, 32'hffff_fffc);
    endtask

    task automatic build_store_load();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 32'h200));
        prog.push_back(enc_addi(2, 0, -1235));
        prog.push_back(enc_sw(2, 1, 4));       // upper half of line 0x200
        prog.push_back(enc_lw(3, 1, 4));
        prog.push_back(enc_addi(4, 0, 77));
        prog.push_back(enc_sw(4, 1, 8));       // lower half of line 0x208
        prog.push_back(enc_lw(5, 1, 8));
        prog.push_back(enc_add(6, 3, 5));      // load result used right away
    endtask

    task automatic test_store_load();
        build_store_load();
        reset_and_load();
        wait_for_commits(8, 600);
        check_commit(0, 0, 1, 32'h0000_0200);
        check_commit(1, 1, 2, 32'hffff_fb2d);
        check_commit(2, 2, 0, 32'd0);
        check_commit(3, 3, 3, 32'hffff_fb2d);
        check_commit(4, 4, 4, 32'd77);
        check_commit(5, 5, 0, 32'd0);
        check_commit(6, 6, 5, 32'd77);
        check_commit(7, 7, 6, 32'hffff_fb7a);
        compare_values("bmem write count", wr_addr.size(), 2);
        check_store(0, 32'h0000_0204, 32'hffff_fb2d);
        check_store(1, 32'h0000_0208, 32'd77);
        s_order = c_order;
        s_pc    = c_pc;
        s_rd    = c_rd;
        s_rdv   = c_rdv;
        saved_mem = mem;
    endtask

    task automatic test_branch();
        prog.delete();
        prog.push_back(enc_addi(1, 0, 7));
        prog.push_back(enc_addi(2, 0, 7));
        prog.push_back(enc_beq(1, 2, 12));     // taken, skips two
        prog.push_back(enc_addi(3, 0, 1));
        prog.push_back(enc_addi(4, 0, 2));
        prog.push_back(enc_addi(5, 0, 3));
        prog.push_back(enc_beq(1, 3, 8));      // not taken since x3 is 0
        prog.push_back(enc_addi(6, 0, 4));
        prog.push_back(enc_addi(7, 5, 1));
        reset_and_load();
        wait_for_commits(9, 600);
        check_commit(0, 0, 1, 32'd7);
        check_commit(1, 1, 2, 32'd7);
        check_commit(2, 2, 0, 32'd0);
        check_commit(3, 5, 5, 32'd3);
        check_commit(4, 6, 0, 32'd0);
        check_commit(5, 7, 6, 32'd4);
        check_commit(6, 8, 7, 32'd4);
        check_commit(7, 9, 0, 32'd0);   // self loop at the end
        check_commit(8, 9, 0, 32'd0);
        foreach (c_pc[k])
        begin
            if (c_pc[k] == reset_pc + 32'd12 || c_pc[k] == reset_pc + 32'd16)
            begin
                $display("squashed instruction at pc %h was committed", c_pc[k]);
                stop_run();
            end
        end
    endtask

    task automatic test_backpressure();
        ready_random = 1'b1;
        build_store_load();
        reset_and_load();
        wait_for_commits(8, 3000);
        for (int k = 0; k < 8; k++)
        begin
            compare_values($sformatf("stalled commit_order[%0d]", k), c_order[k], s_order[k]);
            compare_values($sformatf("stalled commit_pc[%0d]", k), c_pc[k], s_pc[k]);
            compare_values($sformatf("stalled commit_rd[%0d]", k), c_rd[k], s_rd[k]);
            compare_values($sformatf("stalled commit_rd_v[%0d]", k), c_rdv[k], s_rdv[k]);
        end
        for (int i = 0; i < mem_lines; i++)
            compare_values($sformatf("stalled mem line %0d", i), mem[i], saved_mem[i]);
        ready_random = 1'b0;
    endtask

    initial
    begin
        rst          = 1'b1;
        bmem_ready   = 1'b1;
        bmem_raddr   = '0;
        bmem_rdata   = '0;
        bmem_rvalid  = 1'b0;
        ready_random = 1'b0;
        lfsr         = 16'd85;
        samp_rst     = 1'b1;
        samp_rand    = 1'b0;
        rd_acc       = 1'b0;
        wr_acc       = 1'b0;
        pend_v       = 2'b00;
        test_reset_fetch();
        test_alu_sequence();
        test_forwarding();
        test_store_load();
        test_branch();
        test_backpressure();
        $display("NO ERRORS");
        $finish;
    end

endmodule
